// ==== common/cpuCtrl_defs.svh ====
// ----------------------------------------
// field widths and opcode values of the
// control unit. include wherever a width
// or an opcode code is needed
// ----------------------------------------
`ifndef CPU_CTRL_DEFS_SVH
`define CPU_CTRL_DEFS_SVH

// ----------------------------------------
// widths
`define OPCODE_W 4      // instruction opcode
`define STATE_W  5      // sequencer state
`define ALU_W    3      // alu op and alu source select

// ----------------------------------------
// full opcodes
`define OP_LOAD    4'b0000
`define OP_STOPNOP 4'b0001      // nop bit picks nop or stop
`define OP_STORE   4'b0010
`define OP_ADD     4'b0100
`define OP_BZ      4'b0101
`define OP_SUB     4'b0110
`define OP_NAND    4'b1000
`define OP_BNZ     4'b1001
`define OP_BPZ     4'b1101

// low three bits only, top bit is an operand
`define OP3_SHIFT  3'b011
`define OP3_ORI    3'b111

`endif

// ==== common/cpuCtrlPkg.sv ====
// ----------------------------------------
// state, instruction class and alu enums
// shared by the control unit blocks.
// import with cpuCtrlPkg::* in the module
// header
// ----------------------------------------
`default_nettype none
`include "cpuCtrl_defs.svh"

package cpuCtrlPkg;

        // multi-cycle machine states
        typedef enum logic [`STATE_W-1:0] {
                resetState = 5'd0,
                fetch      = 5'd1,      // cycle 1
                decode     = 5'd2,      // cycle 2
                aluExec    = 5'd3,
                aluWrite   = 5'd4,      // shared by alu and shift
                shiftExec  = 5'd5,
                oriLoad    = 5'd6,
                oriExec    = 5'd7,
                oriWrite   = 5'd8,
                loadRead   = 5'd9,
                loadWrite  = 5'd10,
                storeMem   = 5'd11,
                branchPz   = 5'd12,
                branchZ    = 5'd13,
                branchNz   = 5'd14,
                halt       = 5'd15
        } ctrlState_t;

        // what the decoder makes of an opcode
        typedef enum logic [3:0] {
                clsAlu, clsShift, clsOri, clsLoad, clsStore,
                clsBpz, clsBz, clsBnz, clsNop, clsStop, clsIllegal
        } instrClass_t;

        typedef enum logic [`ALU_W-1:0] {
                aluAdd   = 3'b000,
                aluSub   = 3'b001,
                aluOr    = 3'b010,
                aluNand  = 3'b011,
                aluShift = 3'b100
        } aluOp_t;

        // second alu operand
        typedef enum logic [`ALU_W-1:0] {
                srcReg       = 3'b000,
                srcOne       = 3'b001,  // pc increment
                srcBranchImm = 3'b010,
                srcOriImm    = 3'b011,
                srcShiftImm  = 3'b100
        } aluSrcB_t;

endpackage

`default_nettype wire

// ==== src/opcodeDecoder.sv ====
// ----------------------------------------
// combinational opcode decoder. sorts the
// opcode and nop bit into an instruction
// class for the sequencer and picks the
// alu function of arithmetic instructions
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "cpuCtrl_defs.svh"

module opcodeDecoder import cpuCtrlPkg::*;
(
        input  logic [`OPCODE_W-1:0] instr,
        input  logic                 nop,
        output instrClass_t          instrClass,
        output aluOp_t               aluFunc
);

        // priority order matters: shift and ori only look at three bits
        always_comb
        begin
                instrClass = clsIllegal;        // vector codes land here too
                aluFunc    = aluAdd;
                if (instr == `OP_ADD)
                begin
                        instrClass = clsAlu;
                        aluFunc    = aluAdd;
                end
                else if (instr == `OP_SUB)
                begin
                        instrClass = clsAlu;
                        aluFunc    = aluSub;
                end
                else if (instr == `OP_NAND)
                begin
                        instrClass = clsAlu;
                        aluFunc    = aluNand;
                end
                else if (instr[2:0] == `OP3_SHIFT)
                        instrClass = clsShift;
                else if (instr[2:0] == `OP3_ORI)
                        instrClass = clsOri;
                else if (instr == `OP_LOAD)
                        instrClass = clsLoad;
                else if (instr == `OP_STORE)
                        instrClass = clsStore;
                else if (instr == `OP_BPZ)
                        instrClass = clsBpz;
                else if (instr == `OP_BZ)
                        instrClass = clsBz;
                else if (instr == `OP_BNZ)
                        instrClass = clsBnz;
                else if (instr == `OP_STOPNOP)
                begin
                        if (nop)
                                instrClass = clsNop;
                        else
                                instrClass = clsStop;
                end
        end

endmodule

`default_nettype wire

// ==== control/controlSequencer.sv ====
// ----------------------------------------
// state register and next-state logic of
// the multi-cycle machine. every state
// lasts one cycle, decode branches on the
// instruction class from the decoder
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module controlSequencer import cpuCtrlPkg::*;
(
        input  logic        clock,
        input  logic        reset,
        input  instrClass_t instrClass,
        output ctrlState_t  state
);

        ctrlState_t nextState;

        always_ff @(posedge clock or posedge reset)
        begin
                if (reset)
                        state <= resetState;
                else
                        state <= nextState;
        end

        // ----------------------------------------
        // next state
        always_comb
        begin
                nextState = resetState;         // unused encodings recover here
                case (state)
                        resetState: nextState = fetch;
                        fetch:      nextState = decode;
                        decode:
                        begin
                                case (instrClass)
                                        clsAlu:   nextState = aluExec;
                                        clsShift: nextState = shiftExec;
                                        clsOri:   nextState = oriLoad;
                                        clsLoad:  nextState = loadRead;
                                        clsStore: nextState = storeMem;
                                        clsBpz:   nextState = branchPz;
                                        clsBz:    nextState = branchZ;
                                        clsBnz:   nextState = branchNz;
                                        clsNop:   nextState = fetch;    // two-cycle nop
                                        clsStop:  nextState = halt;
                                        default:  nextState = resetState;
                                endcase
                        end

                        // add, sub, nand and shift share the write cycle
                        aluExec:   nextState = aluWrite;
                        shiftExec: nextState = aluWrite;
                        aluWrite:  nextState = fetch;

                        oriLoad:   nextState = oriExec;
                        oriExec:   nextState = oriWrite;
                        oriWrite:  nextState = fetch;

                        loadRead:  nextState = loadWrite;
                        loadWrite: nextState = fetch;

                        storeMem:  nextState = fetch;
                        branchPz:  nextState = fetch;
                        branchZ:   nextState = fetch;
                        branchNz:  nextState = fetch;

                        halt:      nextState = halt;    // only reset leaves
                        default:   nextState = resetState;
                endcase
        end

endmodule

`default_nettype wire

// ==== control/controlWordGen.sv ====
// ----------------------------------------
// datapath control word from the current
// state. every field defaults to zero and
// each state raises only its own fields.
// branch pc writes follow the n and z flags
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module controlWordGen import cpuCtrlPkg::*;
(
        input  ctrlState_t state,
        input  aluOp_t     aluFunc,
        input  logic       n,
        input  logic       z,
        output logic       pcWrite,
        output logic       addrSel,
        output logic       memRead,
        output logic       memWrite,
        output logic       irLoad,
        output logic       r1Sel,
        output logic       mdrLoad,
        output logic       r1r2Load,
        output logic       alu1,
        output aluSrcB_t   alu2,
        output aluOp_t     aluOp,
        output logic       aluOutWrite,
        output logic       rfWrite,
        output logic       regIn,
        output logic       flagWrite
);

        always_comb
        begin
                // ----------------------------------------
                // all-zero word
                pcWrite     = 1'b0;
                addrSel     = 1'b0;
                memRead     = 1'b0;
                memWrite    = 1'b0;
                irLoad      = 1'b0;
                r1Sel       = 1'b0;
                mdrLoad     = 1'b0;
                r1r2Load    = 1'b0;
                alu1        = 1'b0;
                alu2        = srcReg;
                aluOp       = aluAdd;
                aluOutWrite = 1'b0;
                rfWrite     = 1'b0;
                regIn       = 1'b0;
                flagWrite   = 1'b0;

                // ----------------------------------------
                // per-state fields
                case (state)
                        fetch:
                        begin
                                pcWrite = 1'b1;         // pc + 1
                                addrSel = 1'b1;         // address from pc
                                memRead = 1'b1;
                                irLoad  = 1'b1;
                                alu2    = srcOne;
                        end
                        decode:
                        begin
                                r1r2Load = 1'b1;
                        end
                        aluExec:
                        begin
                                alu1        = 1'b1;
                                aluOp       = aluFunc;  // add, sub or nand
                                aluOutWrite = 1'b1;
                                flagWrite   = 1'b1;
                        end
                        aluWrite:
                        begin
                                rfWrite = 1'b1;
                        end
                        shiftExec:
                        begin
                                alu1        = 1'b1;
                                alu2        = srcShiftImm;
                                aluOp       = aluShift;
                                aluOutWrite = 1'b1;
                                flagWrite   = 1'b1;
                        end
                        oriLoad:
                        begin
                                r1Sel    = 1'b1;        // accumulator as r1
                                r1r2Load = 1'b1;
                        end
                        oriExec:
                        begin
                                alu1        = 1'b1;
                                alu2        = srcOriImm;
                                aluOp       = aluOr;
                                aluOutWrite = 1'b1;
                                flagWrite   = 1'b1;
                        end
                        oriWrite:
                        begin
                                r1Sel   = 1'b1;
                                rfWrite = 1'b1;
                        end
                        loadRead:
                        begin
                                memRead = 1'b1;
                                mdrLoad = 1'b1;
                        end
                        loadWrite:
                        begin
                                aluOutWrite = 1'b1;
                                rfWrite     = 1'b1;
                                regIn       = 1'b1;     // write data from mdr
                        end
                        storeMem:
                        begin
                                memWrite = 1'b1;
                        end

                        // branch target is pc plus immediate
                        branchPz:
                        begin
                                alu2    = srcBranchImm;
                                pcWrite = ~n;
                        end
                        branchZ:
                        begin
                                alu2    = srcBranchImm;
                                pcWrite = z;
                        end
                        branchNz:
                        begin
                                alu2    = srcBranchImm;
                                pcWrite = ~z;
                        end
                        default:
                        begin
                                // resetState and halt keep the zero word
                        end
                endcase
        end

endmodule

`default_nettype wire

// ==== src/controlUnit.sv ====
// ----------------------------------------
// top of the control unit. instr and nop
// come from the ir and stay stable until
// the instruction ends, n and z from the
// flag register
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "cpuCtrl_defs.svh"

module controlUnit import cpuCtrlPkg::*;
(
        input  logic                 clock,
        input  logic                 reset,
        input  logic [`OPCODE_W-1:0] instr,
        input  logic                 nop,
        input  logic                 n,
        input  logic                 z,
        output logic                 pcWrite,
        output logic                 addrSel,
        output logic                 memRead,
        output logic                 memWrite,
        output logic                 irLoad,
        output logic                 r1Sel,
        output logic                 mdrLoad,
        output logic                 r1r2Load,
        output logic                 alu1,
        output aluSrcB_t             alu2,
        output aluOp_t               aluOp,
        output logic                 aluOutWrite,
        output logic                 rfWrite,
        output logic                 regIn,
        output logic                 flagWrite,
        output ctrlState_t           state
);

        instrClass_t instrClass;
        aluOp_t      aluFunc;

        opcodeDecoder decoder (
                .instr      (instr),
                .nop        (nop),
                .instrClass (instrClass),
                .aluFunc    (aluFunc)
        );

        controlSequencer sequencer (
                .clock      (clock),
                .reset      (reset),
                .instrClass (instrClass),
                .state      (state)
        );

        // control word from the state, alu function and flags
        controlWordGen wordGen (
                .state       (state),
                .aluFunc     (aluFunc),
                .n           (n),
                .z           (z),
                .pcWrite     (pcWrite),
                .addrSel     (addrSel),
                .memRead     (memRead),
                .memWrite    (memWrite),
                .irLoad      (irLoad),
                .r1Sel       (r1Sel),
                .mdrLoad     (mdrLoad),
                .r1r2Load    (r1r2Load),
                .alu1        (alu1),
                .alu2        (alu2),
                .aluOp       (aluOp),
                .aluOutWrite (aluOutWrite),
                .rfWrite     (rfWrite),
                .regIn       (regIn),
                .flagWrite   (flagWrite)
        );

endmodule

`default_nettype wire

// ==== testbench/tbClock.sv ====
// ----------------------------------------
// testbench clock and power-on reset.
// 4 ns period, reset held for 16 cycles
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tbClock
(
        output logic clock,
        output logic reset
);

        initial
        begin
                clock = 1'b0;
                reset = 1'b1;
                repeat (16) @(posedge clock);
                reset <= 1'b0;
        end

        always #2 clock = ~clock;       // 4 ns period

endmodule

`default_nettype wire

// ==== testbench/controlUnitSva.sv ====
// ----------------------------------------
// concurrent checks on the sequencer,
// bound into every controlSequencer
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module controlUnitSva import cpuCtrlPkg::*;
(
        input logic       clock,
        input logic       reset,
        input ctrlState_t state
);

        haltHolds: assert property (@(posedge clock) disable iff (reset)
                state == halt |=> state == halt)
        else $error("halt was left without reset");

        resetToFetch: assert property (@(posedge clock) disable iff (reset)
                state == resetState |=> state == fetch)
        else $error("resetState was not followed by fetch");

        // decode lasts one cycle
        decodeLeaves: assert property (@(posedge clock) disable iff (reset)
                state == decode |=> state != decode)
        else $error("decode held for more than one cycle");

endmodule

bind controlSequencer controlUnitSva sva (
        .clock (clock),
        .reset (reset),
        .state (state)
);

`default_nettype wire

// ==== testbench/controlUnitTb.sv ====
// ----------------------------------------
// testbench of the control unit. random
// opcode stream, a state and control-word
// model, checks at each falling edge
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "cpuCtrl_defs.svh"

module controlUnitTb import cpuCtrlPkg::*;
();

        localparam int NUM_INSTR = 400;
        localparam int BLOCK = 50;      // instructions per test
        localparam int TIMEOUT_CYCLES = (NUM_INSTR * 5 + 20 * 20) * 3 / 2 + 16;

        typedef struct packed {
                logic pcWrite, addrSel, memRead, memWrite, irLoad, r1Sel, mdrLoad;
                logic r1r2Load, alu1;
                aluSrcB_t alu2;
                aluOp_t aluOp;
                logic aluOutWrite, rfWrite, regIn, flagWrite;
        } ctrlWord_t;

        logic clock, powerOnReset, haltReset, reset;
        logic [`OPCODE_W-1:0] instr;
        logic nop, n, z;
        logic pcWrite, addrSel, memRead, memWrite, irLoad, r1Sel, mdrLoad, r1r2Load, alu1;
        logic aluOutWrite, rfWrite, regIn, flagWrite;
        aluSrcB_t alu2;
        aluOp_t aluOp;
        ctrlState_t state, expState, prevState;
        ctrlWord_t expWord;
        int instrCount, errorCount, blockErrors, cycleCount, haltCycles, sinceFetch;
        logic fetchSeen;

        assign reset = powerOnReset | haltReset;

        tbClock clockGen (.clock(clock), .reset(powerOnReset));

        controlUnit uut (
                .clock(clock), .reset(reset), .instr(instr), .nop(nop), .n(n), .z(z),
                .pcWrite(pcWrite), .addrSel(addrSel), .memRead(memRead),
                .memWrite(memWrite), .irLoad(irLoad), .r1Sel(r1Sel), .mdrLoad(mdrLoad),
                .r1r2Load(r1r2Load), .alu1(alu1), .alu2(alu2), .aluOp(aluOp),
                .aluOutWrite(aluOutWrite), .rfWrite(rfWrite), .regIn(regIn),
                .flagWrite(flagWrite), .state(state)
        );

        // ----------------------------------------
        // reference model
        function automatic ctrlState_t modelNext(ctrlState_t s, logic [3:0] op, logic nb);
                case (s)
                        resetState, aluWrite, oriWrite, loadWrite: return fetch;
                        fetch:     return decode;
                        aluExec, shiftExec: return aluWrite;
                        oriLoad:   return oriExec;
                        oriExec:   return oriWrite;
                        loadRead:  return loadWrite;
                        halt:      return halt;
                        decode:
                                casez (op)
                                        `OP_ADD, `OP_SUB, `OP_NAND: return aluExec;
                                        4'b?011: return shiftExec;
                                        4'b?111: return oriLoad;
                                        `OP_LOAD:  return loadRead;
                                        `OP_STORE: return storeMem;
                                        `OP_BPZ:   return branchPz;
                                        `OP_BZ:    return branchZ;
                                        `OP_BNZ:   return branchNz;
                                        `OP_STOPNOP: return nb ? fetch : halt;
                                        default:   return resetState;  // illegal, vector
                                endcase
                        default:   return fetch;      // store and branches
                endcase
        endfunction

        function automatic ctrlWord_t modelWord(ctrlState_t s, logic [3:0] op,
                                                logic nf, logic zf);
                ctrlWord_t w;
                w = '0;
                case (s)
                        fetch:
                        begin
                                w.pcWrite = 1'b1;
                                w.addrSel = 1'b1;
                                w.memRead = 1'b1;
                                w.irLoad = 1'b1;
                                w.alu2 = srcOne;
                        end
                        decode: w.r1r2Load = 1'b1;
                        aluExec:
                        begin
                                w.alu1 = 1'b1;
                                w.aluOutWrite = 1'b1;
                                w.flagWrite = 1'b1;
                                if (op == `OP_SUB)
                                        w.aluOp = aluSub;
                                else if (op == `OP_NAND)
                                        w.aluOp = aluNand;
                                else
                                        w.aluOp = aluAdd;
                        end
                        aluWrite: w.rfWrite = 1'b1;
                        shiftExec, oriExec:
                        begin
                                w.alu1 = 1'b1;
                                w.aluOutWrite = 1'b1;
                                w.flagWrite = 1'b1;
                                w.alu2 = s == shiftExec ? srcShiftImm : srcOriImm;
                                w.aluOp = s == shiftExec ? aluShift : aluOr;
                        end
                        oriLoad:
                        begin
                                w.r1Sel = 1'b1;
                                w.r1r2Load = 1'b1;
                        end
                        oriWrite:
                        begin
                                w.r1Sel = 1'b1;
                                w.rfWrite = 1'b1;
                        end
                        loadRead:
                        begin
                                w.memRead = 1'b1;
                                w.mdrLoad = 1'b1;
                        end
                        loadWrite:
                        begin
                                w.aluOutWrite = 1'b1;
                                w.rfWrite = 1'b1;
                                w.regIn = 1'b1;
                        end
                        storeMem:  w.memWrite = 1'b1;
                        branchPz:
                        begin
                                w.alu2 = srcBranchImm;
                                w.pcWrite = ~nf;
                        end
                        branchZ:
                        begin
                                w.alu2 = srcBranchImm;
                                w.pcWrite = zf;
                        end
                        branchNz:
                        begin
                                w.alu2 = srcBranchImm;
                                w.pcWrite = ~zf;
                        end
                        default:   w = '0;
                endcase
                return w;
        endfunction

        // fetch-to-fetch length per timing table
        function automatic int cyclesOf(logic [3:0] op, logic nb);
                casez (op)
                        `OP_ADD, `OP_SUB, `OP_NAND, 4'b?011, `OP_LOAD: return 4;
                        4'b?111: return 5;
                        `OP_STORE, `OP_BPZ, `OP_BZ, `OP_BNZ: return 3;
                        `OP_STOPNOP: return nb ? 2 : 0;
                        default: return 3;
                endcase
        endfunction

        task automatic checkValue(string name, logic [4:0] got, logic [4:0] exp);
                assert (got === exp)
                else
                begin
                        $display("Mismatch %s: got 0x%0h expected 0x%0h at cycle %0d",
                                 name, got, exp, cycleCount);
                        errorCount++;
                end
        endtask

        task automatic pickOpcode(output logic [3:0] op);
                int unsigned choice;
                choice = $urandom % 16;
                if (choice >= 12)
                        op = 4'($urandom % 16);         // any code, vector ones too
                else
                        case ($urandom % 11)
                                0: op = `OP_LOAD;
                                1: op = `OP_STOPNOP;
                                2: op = `OP_STORE;
                                3: op = `OP_ADD;
                                4: op = `OP_BZ;
                                5: op = `OP_SUB;
                                6: op = `OP_NAND;
                                7: op = `OP_BNZ;
                                8: op = `OP_BPZ;
                                9: op = {1'($urandom % 2), `OP3_SHIFT};
                                default: op = {1'($urandom % 2), `OP3_ORI};
                        endcase
        endtask

        always @(posedge clock or posedge reset)
        begin
                if (reset)
                        expState <= resetState;
                else
                        expState <= modelNext(expState, instr, nop);
        end

        // ----------------------------------------
        // stimulus, new instruction as fetch ends
        always @(posedge clock)
        begin : stimulus
                logic [3:0] op;
                cycleCount <= cycleCount + 1;
                if (!reset && expState == fetch && instrCount < NUM_INSTR)
                begin
                        pickOpcode(op);
                        instr <= op;
                        nop <= 1'($urandom % 2);
                        n <= 1'($urandom % 2);
                        z <= 1'($urandom % 2);
                        instrCount <= instrCount + 1;
                        if (instrCount > 0 && instrCount % BLOCK == 0)
                        begin
                                $display("test %0d done, %0d errors", instrCount / BLOCK,
                                         errorCount - blockErrors);
                                blockErrors <= errorCount;
                        end
                end
                if (haltReset)
                        haltReset <= 1'b0;
                else if (expState == halt)
                begin
                        haltCycles <= haltCycles == 2 ? 0 : haltCycles + 1;
                        haltReset <= haltCycles == 2;   // three halt cycles then reset
                end
        end

        // ----------------------------------------
        // checks where outputs are stable
        always @(negedge clock)
        begin
                expWord = modelWord(expState, instr, n, z);
                checkValue("state", 5'(state), 5'(expState));
                checkValue("pcWrite", 5'(pcWrite), 5'(expWord.pcWrite));
                checkValue("addrSel", 5'(addrSel), 5'(expWord.addrSel));
                checkValue("memRead", 5'(memRead), 5'(expWord.memRead));
                checkValue("memWrite", 5'(memWrite), 5'(expWord.memWrite));
                checkValue("irLoad", 5'(irLoad), 5'(expWord.irLoad));
                checkValue("r1Sel", 5'(r1Sel), 5'(expWord.r1Sel));
                checkValue("mdrLoad", 5'(mdrLoad), 5'(expWord.mdrLoad));
                checkValue("r1r2Load", 5'(r1r2Load), 5'(expWord.r1r2Load));
                checkValue("alu1", 5'(alu1), 5'(expWord.alu1));
                checkValue("alu2", 5'(alu2), 5'(expWord.alu2));
                checkValue("aluOp", 5'(aluOp), 5'(expWord.aluOp));
                checkValue("aluOutWrite", 5'(aluOutWrite), 5'(expWord.aluOutWrite));
                checkValue("rfWrite", 5'(rfWrite), 5'(expWord.rfWrite));
                checkValue("regIn", 5'(regIn), 5'(expWord.regIn));
                checkValue("flagWrite", 5'(flagWrite), 5'(expWord.flagWrite));
                if (!reset && state == prevState && state != halt && state != resetState)
                begin
                        assert (1'b0)
                        else
                        begin
                                $display("state 0x%0h did not advance at cycle %0d",
                                         state, cycleCount);
                                errorCount++;
                        end
                end
                if (reset)
                        fetchSeen <= 1'b0;
                else if (state == fetch)
                begin
                        if (fetchSeen)
                                checkValue("fetchCycles", 5'(sinceFetch),
                                           5'(cyclesOf(instr, nop)));
                        fetchSeen <= 1'b1;
                        sinceFetch <= 1;
                end
                else
                        sinceFetch <= sinceFetch + 1;
                prevState <= state;
        end

        always @(posedge clock)
        begin
                if (cycleCount >= TIMEOUT_CYCLES)
                begin
                        $display("timeout after %0d cycles, run did not complete", cycleCount);
                        $display("Errors found");
                        $finish;
                end
        end

        initial
        begin
                void'($urandom(32'h7da4));
                instr = `OP_LOAD;
                nop = 1'b0;
                n = 1'b0;
                z = 1'b0;
                haltReset = 1'b0;
                instrCount = 0;
                errorCount = 0;
                blockErrors = 0;
                cycleCount = 0;
                haltCycles = 0;
                sinceFetch = 0;
                fetchSeen = 1'b0;
                prevState = resetState;
                wait (instrCount == NUM_INSTR && expState == fetch && !reset);
                @(negedge clock);
                @(posedge clock);
                $display("test %0d done, %0d errors", NUM_INSTR / BLOCK,
                         errorCount - blockErrors);
                $display("%0d instructions, %0d cycles, %0d errors", instrCount, cycleCount,
                         errorCount);
                if (errorCount == 0)
                        $display("No errors");
                else
                        $display("Errors found");
                $finish;
        end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+common
common/cpuCtrlPkg.sv
src/opcodeDecoder.sv
control/controlSequencer.sv
control/controlWordGen.sv
src/controlUnit.sv
testbench/tbClock.sv
testbench/controlUnitSva.sv
testbench/controlUnitTb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module controlUnitTb \
        -o simControlUnit > build.log 2>&1 \
        && ./obj_dir/simControlUnit > sim.log 2>&1 \
        || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0
